/* Makefile */
# verilator build and run for the switch receive port

VERILATOR ?= verilator
TOP       ?= tb_switch_rx
RTL_TOP   ?= switch_rx_port
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)
PASS_MSG  ?= STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only hw/rx_tx_pkg.sv hw/gmii_cdc_fifo.sv hw/rx_mac_control.sv \
		hw/mac_learn_table.sv hw/switch_rx_port.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

/* all.f */
hw/rx_tx_pkg.sv
hw/gmii_cdc_fifo.sv
hw/rx_mac_control.sv
hw/mac_learn_table.sv
hw/switch_rx_port.sv
sim/rx_checker.sv
sim/tb_switch_rx.sv

/* hw/gmii_cdc_fifo.sv */
module gmii_cdc_fifo (
    // write side, gmii rx clock
    input  logic                             wclk_i,
    input  logic                             wrst_n_i,
    input  logic                             w_en_i,
    input  logic [rx_tx_pkg::DATA_WIDTH-1:0] w_data_i,
    output logic                             w_full_o,
    // read side, switch clock
    input  logic                             rclk_i,
    input  logic                             rrst_n_i,
    input  logic                             r_en_i,
    output logic [rx_tx_pkg::DATA_WIDTH-1:0] r_data_o,   // valid the cycle after r_en_i
    output logic                             r_empty_o
);
    import rx_tx_pkg::*;

    logic [DATA_WIDTH-1:0] mem [2**FIFO_ADDR_W];

    // pointers carry one extra wrap bit
    logic [FIFO_ADDR_W:0] wbin, wgray, wbin_nxt, wgray_nxt;
    logic [FIFO_ADDR_W:0] rbin, rgray, rbin_nxt, rgray_nxt;
    logic [FIFO_ADDR_W:0] rgray_w1, rgray_w2;   // read pointer seen by the writer
    logic [FIFO_ADDR_W:0] wgray_r1, wgray_r2;   // write pointer seen by the reader
    logic                 w_do, r_do;

    assign w_do = w_en_i && !w_full_o;   // writes into a full fifo are lost
    assign r_do = r_en_i && !r_empty_o;

    assign wbin_nxt  = wbin + {{FIFO_ADDR_W{1'b0}}, w_do};
    assign wgray_nxt = (wbin_nxt >> 1) ^ wbin_nxt;
    assign rbin_nxt  = rbin + {{FIFO_ADDR_W{1'b0}}, r_do};
    assign rgray_nxt = (rbin_nxt >> 1) ^ rbin_nxt;

    always_ff @(posedge wclk_i) begin
        if (w_do) mem[wbin[FIFO_ADDR_W-1:0]] <= w_data_i;
    end

    always_ff @(posedge wclk_i or negedge wrst_n_i) begin
        if (!wrst_n_i) begin
            wbin     <= '0;
            wgray    <= '0;
            rgray_w1 <= '0;
            rgray_w2 <= '0;
            w_full_o <= 1'b0;
        end else begin
            wbin     <= wbin_nxt;
            wgray    <= wgray_nxt;
            rgray_w1 <= rgray;      // two flop sync of the read pointer
            rgray_w2 <= rgray_w1;
            // full when the writer is one lap ahead, top two gray bits flipped
            w_full_o <= (wgray_nxt == {~rgray_w2[FIFO_ADDR_W:FIFO_ADDR_W-1],
                                       rgray_w2[FIFO_ADDR_W-2:0]});
        end
    end

    always_ff @(posedge rclk_i) begin
        if (r_do) r_data_o <= mem[rbin[FIFO_ADDR_W-1:0]];   // holds between reads
    end

    always_ff @(posedge rclk_i or negedge rrst_n_i) begin
        if (!rrst_n_i) begin
            rbin      <= '0;
            rgray     <= '0;
            wgray_r1  <= '0;
            wgray_r2  <= '0;
            r_empty_o <= 1'b1;
        end else begin
            rbin      <= rbin_nxt;
            rgray     <= rgray_nxt;
            wgray_r1  <= wgray;     // two flop sync of the write pointer
            wgray_r2  <= wgray_r1;
            r_empty_o <= (rgray_nxt == wgray_r2);
        end
    end

endmodule

/* hw/mac_learn_table.sv */
module mac_learn_table (
    input  logic switch_clk,
    input  logic switch_rst_n,
    input  logic [rx_tx_pkg::MAC_BYTES-1:0][rx_tx_pkg::DATA_WIDTH-1:0] mac_dst_addr_i,
    input  logic [rx_tx_pkg::MAC_BYTES-1:0][rx_tx_pkg::DATA_WIDTH-1:0] mac_src_addr_i,
    input  logic frame_eof_i,
    input  logic frame_error_i,
    output logic lookup_valid_o,   // one cycle, the cycle after a good eof rises
    output logic dst_hit_o         // dst already learned, qualified by lookup_valid_o
);
    import rx_tx_pkg::*;

    logic [TABLE_DEPTH-1:0][MAC_BYTES*DATA_WIDTH-1:0] entry;
    logic [TABLE_DEPTH-1:0]                           entry_vld;
    logic [$clog2(TABLE_DEPTH)-1:0]                   wr_ptr;   // oldest entry, replaced next
    logic                                             eof_q;
    logic                                             learn;
    logic                                             dst_match, src_match;

    assign learn = frame_eof_i && !eof_q && !frame_error_i;   // good frame just closed

    // parallel compare against every live entry
    always_comb begin
        dst_match = 1'b0;
        src_match = 1'b0;
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            if (entry_vld[i] && entry[i] == mac_dst_addr_i) dst_match = 1'b1;
            if (entry_vld[i] && entry[i] == mac_src_addr_i) src_match = 1'b1;
        end
    end

    always_ff @(posedge switch_clk or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            entry_vld      <= '0;
            wr_ptr         <= '0;
            eof_q          <= 1'b0;
            lookup_valid_o <= 1'b0;
            dst_hit_o      <= 1'b0;
        end else begin
            eof_q          <= frame_eof_i;
            lookup_valid_o <= learn;
            dst_hit_o      <= learn && dst_match;   // sees the table before this frame's src
            if (learn && !src_match) begin
                entry_vld[wr_ptr] <= 1'b1;
                wr_ptr            <= wr_ptr + 1'b1;   // round robin, a repeat src keeps its slot
            end
        end
    end

    always_ff @(posedge switch_clk) begin
        if (learn && !src_match) entry[wr_ptr] <= mac_src_addr_i;
    end

endmodule

/* hw/rx_mac_control.sv */
module rx_mac_control (
    // gmii receive, phy clock
    input  logic                             gmii_rx_clk_i,
    input  logic [rx_tx_pkg::DATA_WIDTH-1:0] gmii_rx_data_i,
    input  logic                             gmii_rx_dv_i,
    input  logic                             gmii_rx_er_i,
    input  logic                             switch_clk,
    input  logic                             switch_rst_n,
    // captured addresses, first wire byte in the top byte lane
    output logic [rx_tx_pkg::MAC_BYTES-1:0][rx_tx_pkg::DATA_WIDTH-1:0] mac_dst_addr_o,
    output logic [rx_tx_pkg::MAC_BYTES-1:0][rx_tx_pkg::DATA_WIDTH-1:0] mac_src_addr_o,
    // frame stream, a byte is taken when valid and grant are both high
    output logic [rx_tx_pkg::DATA_WIDTH-1:0] frame_data_o,
    output logic                             frame_valid_o,
    input  logic                             frame_grant_i,
    output logic                             frame_sof_o,   // with first dst byte
    output logic                             frame_eof_o,   // sticky until next sof
    output logic                             frame_error_o  // valid while eof high
);
    import rx_tx_pkg::*;

    typedef enum logic [1:0] {IDLE, PREAMBLE, HEADER, PAYLOAD} state_t;

    state_t                      state, state_d;
    logic [1:0]                  gmii_rst_sync;      // switch reset in the phy domain
    logic [1:0]                  dv_sync, er_sync;
    logic                        rx_dv, rx_er;
    logic [DATA_WIDTH-1:0]       fifo_dout;
    logic                        fifo_rd_en, fifo_empty, fifo_full;
    logic                        rd_pend;             // fifo_dout holds a fresh byte
    logic                        freeze, take;
    logic [4:0]                  pos_cnt, pos_cnt_d;  // byte position up to HEADER_END
    logic [31:0]                 crc_reg, crc_d;
    logic [3:0][31:0]            crc_hist;            // crc before each of the last bytes
    logic [2:0][DATA_WIDTH-1:0]  data_hist;           // three bytes before frame_data_o
    logic                        er_seen, fcs_bad;
    logic [MAC_BYTES-1:0][DATA_WIDTH-1:0] dst_d, src_d;
    logic [DATA_WIDTH-1:0]       data_d;
    logic                        valid_d, sof_d, eof_d, error_d;

    always_ff @(posedge gmii_rx_clk_i or negedge switch_rst_n) begin
        if (!switch_rst_n) gmii_rst_sync <= 2'b00;   // assert at once, release on gmii clock
        else gmii_rst_sync <= {gmii_rst_sync[0], 1'b1};
    end

    gmii_cdc_fifo u_cdc_fifo (
        .wclk_i    (gmii_rx_clk_i),
        .wrst_n_i  (gmii_rst_sync[1]),
        .w_en_i    (gmii_rx_dv_i && !gmii_rx_er_i && !fifo_full), // er bytes never enter
        .w_data_i  (gmii_rx_data_i),
        .w_full_o  (fifo_full),
        .rclk_i    (switch_clk),
        .rrst_n_i  (switch_rst_n),
        .r_en_i    (fifo_rd_en),
        .r_data_o  (fifo_dout),
        .r_empty_o (fifo_empty)
    );

    always_ff @(posedge switch_clk or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            dv_sync <= 2'b00;
            er_sync <= 2'b00;
        end else begin
            dv_sync <= {dv_sync[0], gmii_rx_dv_i};
            er_sync <= {er_sync[0], gmii_rx_er_i};
        end
    end
    assign rx_dv = dv_sync[1];
    assign rx_er = er_sync[1];

    // memory side back-pressure only bites once bytes are being streamed
    assign freeze = !frame_grant_i && (state == HEADER || state == PAYLOAD);
    assign take   = rd_pend && !freeze && (state == HEADER || state == PAYLOAD);
    // fcs goes msb first on the wire and equals the crc taken before it
    assign fcs_bad = crc_hist[3] != {data_hist, frame_data_o};

    always_comb begin
        state_d    = state;
        pos_cnt_d  = pos_cnt;
        crc_d      = crc_reg;
        dst_d      = mac_dst_addr_o;
        src_d      = mac_src_addr_o;
        data_d     = frame_data_o;
        valid_d    = 1'b0;
        sof_d      = 1'b0;
        eof_d      = frame_eof_o;
        error_d    = frame_error_o;
        fifo_rd_en = !fifo_empty && !freeze;
        case (state)
            IDLE: begin
                crc_d = CRC_INIT;
                if (rd_pend && fifo_dout == PREAMBLE_BYTE) begin
                    pos_cnt_d = 5'd1;
                    state_d   = PREAMBLE;
                end
            end
            PREAMBLE: begin
                if (rd_pend) begin
                    if (pos_cnt == SFD_POS) state_d = (fifo_dout == SFD_BYTE) ? HEADER : IDLE;
                    else if (fifo_dout != PREAMBLE_BYTE) state_d = IDLE;   // broken preamble
                    pos_cnt_d = pos_cnt + 5'd1;
                end
            end
            HEADER, PAYLOAD: begin
                if (rd_pend) begin
                    crc_d   = crc32_next(fifo_dout, crc_reg);
                    data_d  = fifo_dout;
                    valid_d = 1'b1;
                    if (state == HEADER) begin
                        if (pos_cnt == DST_FIRST) begin
                            sof_d   = 1'b1;
                            eof_d   = 1'b0;
                            error_d = 1'b0;
                        end
                        if (pos_cnt < SRC_FIRST) begin
                            dst_d = {mac_dst_addr_o[MAC_BYTES-2:0], fifo_dout};
                        end else if (pos_cnt < TYPE_FIRST) begin
                            src_d = {mac_src_addr_o[MAC_BYTES-2:0], fifo_dout};
                        end
                        if (pos_cnt == HEADER_END) state_d = PAYLOAD;   // ethertype passes through
                        pos_cnt_d = pos_cnt + 5'd1;
                    end
                end else if (!rx_dv && fifo_empty) begin   // sender done and fifo drained
                    eof_d   = 1'b1;
                    error_d = er_seen || fcs_bad || (state == HEADER); // runt counts as bad
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge switch_clk or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            state          <= IDLE;
            rd_pend        <= 1'b0;
            pos_cnt        <= '0;
            crc_reg        <= CRC_INIT;
            mac_dst_addr_o <= '0;
            mac_src_addr_o <= '0;
            frame_data_o   <= '0;
            frame_valid_o  <= 1'b0;
            frame_sof_o    <= 1'b0;
            frame_eof_o    <= 1'b0;
            frame_error_o  <= 1'b0;
            er_seen        <= 1'b0;
        end else if (freeze) begin
            er_seen <= er_seen || rx_er;
            if (!rx_dv) begin   // frame ended under a stall, close it as bad
                state         <= IDLE;
                frame_valid_o <= 1'b0;
                frame_sof_o   <= 1'b0;
                frame_eof_o   <= 1'b1;
                frame_error_o <= 1'b1;
            end
        end else begin
            state          <= state_d;
            rd_pend        <= fifo_rd_en;
            pos_cnt        <= pos_cnt_d;
            crc_reg        <= crc_d;
            mac_dst_addr_o <= dst_d;
            mac_src_addr_o <= src_d;
            frame_data_o   <= data_d;
            frame_valid_o  <= valid_d;
            frame_sof_o    <= sof_d;
            frame_eof_o    <= eof_d;
            frame_error_o  <= error_d;
            er_seen        <= (state == IDLE) ? 1'b0 : (er_seen || rx_er);
        end
    end

    // shift registers line up the pre-fcs crc with the four fcs bytes at eof
    always_ff @(posedge switch_clk) begin
        if (take) begin
            crc_hist  <= {crc_hist[2:0], crc_reg};
            data_hist <= {data_hist[1:0], frame_data_o};
        end
    end

endmodule

/* hw/rx_tx_pkg.sv */
package rx_tx_pkg;

    localparam int DATA_WIDTH = 8;                   // gmii and frame byte width
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE = 8'hD5;
    localparam int MAC_BYTES = 6;                    // bytes per mac address

    // byte positions within a frame, preamble starts at 0 and the sfd sits at 7
    localparam logic [4:0] HEADER_END = 5'd21;       // last ethertype byte
    localparam logic [4:0] SFD_POS = 5'(HEADER_END - 2 * MAC_BYTES - 2);
    localparam logic [4:0] DST_FIRST = SFD_POS + 5'd1;
    localparam logic [4:0] SRC_FIRST = DST_FIRST + 5'(MAC_BYTES);
    localparam logic [4:0] TYPE_FIRST = SRC_FIRST + 5'(MAC_BYTES);

    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;
    localparam logic [31:0] CRC_POLY = 32'hEDB8_8320; // reflected 802.3 polynomial

    localparam int FIFO_ADDR_W = 4;                  // 16 byte cdc fifo
    localparam int TABLE_DEPTH = 8;                  // learning table entries

    // one byte of the reflected ethernet crc-32, lsb of the byte first
    function automatic logic [31:0] crc32_next(
        input logic [DATA_WIDTH-1:0] data,
        input logic [31:0]           crc
    );
        logic [31:0] c;
        c = crc ^ {24'h0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

endpackage

/* hw/switch_rx_port.sv */
module switch_rx_port (
    input  logic                             gmii_rx_clk_i,
    input  logic [rx_tx_pkg::DATA_WIDTH-1:0] gmii_rx_data_i,
    input  logic                             gmii_rx_dv_i,
    input  logic                             gmii_rx_er_i,
    input  logic                             switch_clk,
    input  logic                             switch_rst_n,
    input  logic                             frame_grant_i,
    output logic [rx_tx_pkg::DATA_WIDTH-1:0] frame_data_o,
    output logic                             frame_valid_o,
    output logic                             frame_sof_o,
    output logic                             frame_eof_o,
    output logic                             frame_error_o,
    output logic [rx_tx_pkg::MAC_BYTES-1:0][rx_tx_pkg::DATA_WIDTH-1:0] mac_dst_addr_o,
    output logic [rx_tx_pkg::MAC_BYTES-1:0][rx_tx_pkg::DATA_WIDTH-1:0] mac_src_addr_o,
    output logic                             lookup_valid_o,
    output logic                             dst_hit_o
);

    rx_mac_control u_rx_mac (
        .gmii_rx_clk_i  (gmii_rx_clk_i),
        .gmii_rx_data_i (gmii_rx_data_i),
        .gmii_rx_dv_i   (gmii_rx_dv_i),
        .gmii_rx_er_i   (gmii_rx_er_i),
        .switch_clk     (switch_clk),
        .switch_rst_n   (switch_rst_n),
        .mac_dst_addr_o (mac_dst_addr_o),
        .mac_src_addr_o (mac_src_addr_o),
        .frame_data_o   (frame_data_o),
        .frame_valid_o  (frame_valid_o),
        .frame_grant_i  (frame_grant_i),
        .frame_sof_o    (frame_sof_o),
        .frame_eof_o    (frame_eof_o),
        .frame_error_o  (frame_error_o)
    );

    // table watches the same eof and error the memory side sees
    mac_learn_table u_learn (
        .switch_clk     (switch_clk),
        .switch_rst_n   (switch_rst_n),
        .mac_dst_addr_i (mac_dst_addr_o),
        .mac_src_addr_i (mac_src_addr_o),
        .frame_eof_i    (frame_eof_o),
        .frame_error_i  (frame_error_o),
        .lookup_valid_o (lookup_valid_o),
        .dst_hit_o      (dst_hit_o)
    );

endmodule

/* sim/frames_input.txt */
# dst_mac src_mac payload_len first_byte(hex) fcs_corrupt er_pos stall_idx
# er_pos and stall_idx count frame bytes from the first dst byte, 0 means none
0a0000000001 020000000001 46 10 0 0 0
020000000001 020000000002 50 20 0 0 0
020000000002 020000000003 46 30 1 0 0
020000000003 020000000004 60 40 0 0 0
020000000004 020000000005 64 50 0 33 0
020000000005 020000000006 46 60 0 0 0
020000000006 020000000007 80 70 0 0 20
020000000004 020000000008 46 80 0 0 40
0a0000000002 020000000009 46 90 0 0 0
020000000009 020000000001 46 a0 0 0 0
0a0000000003 02000000000a 52 b0 0 0 0
020000000001 02000000000b 46 c0 0 0 0
020000000001 02000000000c 46 d0 0 0 0
020000000002 02000000000d 48 e0 0 0 0
02000000000b 02000000000e 70 f0 0 0 30
020000000007 02000000000f 100 01 0 0 0

/* sim/rx_checker.sv */
module rx_checker (
    input logic        switch_clk,
    input logic [7:0]  frame_data_i,
    input logic        frame_valid_i,
    input logic        frame_grant_i,
    input logic        frame_sof_i,
    input logic        frame_eof_i,
    input logic        frame_error_i,
    input logic [47:0] mac_dst_addr_i,
    input logic [47:0] mac_src_addr_i,
    input logic        lookup_valid_i,
    input logic        dst_hit_i
);
    logic [7:0]  exp_byte[$];   // all frames back to back
    int          exp_len[$];
    logic        exp_err[$], exp_hit[$];
    logic [47:0] exp_dst[$], exp_src[$];
    logic [7:0]  got[$];        // bytes taken in the current frame
    logic        in_frame = 0, eof_q = 0, lookup_due = 0, due_hit = 0;
    int          data_errs = 0, ctrl_errs = 0, lookup_errs = 0, frames_done = 0;

    task automatic push_byte(input logic [7:0] b);
        exp_byte.push_back(b);
    endtask

    task automatic push_frame(input int n, input logic e, input logic h,
                              input logic [47:0] d, input logic [47:0] s);
        exp_len.push_back(n);
        exp_err.push_back(e);
        exp_hit.push_back(h);
        exp_dst.push_back(d);
        exp_src.push_back(s);
    endtask

    task automatic close_frame();
        int n;
        logic e, h;
        logic [47:0] d, s;
        logic [7:0] b;
        if (exp_len.size() == 0) begin
            $display("frame closed with no frame expected");
            ctrl_errs++;
            return;
        end
        n = exp_len.pop_front();
        e = exp_err.pop_front();
        h = exp_hit.pop_front();
        d = exp_dst.pop_front();
        s = exp_src.pop_front();
        for (int k = 0; k < n; k++) begin
            b = exp_byte.pop_front();
            // er frames lose a byte in the fifo, contents not compared
            if (!e && k < got.size() && got[k] !== b) begin
                $display("** Error: frame_data_o frame %0d byte %0d expected %h got %h",
                         frames_done, k, b, got[k]);
                data_errs++;
            end
        end
        if (!e && got.size() != n) begin
            $display("** Error: frame_valid_o byte count frame %0d expected %h got %h",
                     frames_done, n, got.size());
            data_errs++;
        end
        if (frame_error_i !== e) begin
            $display("** Error: frame_error_o frame %0d expected %h got %h",
                     frames_done, e, frame_error_i);
            ctrl_errs++;
        end
        if (!e && mac_dst_addr_i !== d) begin
            $display("** Error: mac_dst_addr_o expected %h got %h", d, mac_dst_addr_i);
            ctrl_errs++;
        end
        if (!e && mac_src_addr_i !== s) begin
            $display("** Error: mac_src_addr_o expected %h got %h", s, mac_src_addr_i);
            ctrl_errs++;
        end
        lookup_due = !e;   // table answers on the next cycle
        due_hit    = h;
        frames_done++;
    endtask

    always @(posedge switch_clk) begin
        if (lookup_due) begin
            if (lookup_valid_i !== 1'b1) begin
                $display("lookup_valid_o did not pulse after a good end of frame");
                lookup_errs++;
            end else if (dst_hit_i !== due_hit) begin
                $display("** Error: dst_hit_o expected %h got %h", due_hit, dst_hit_i);
                lookup_errs++;
            end
        end else if (lookup_valid_i === 1'b1) begin
            $display("lookup_valid_o pulsed without a good end of frame");
            lookup_errs++;
        end
        lookup_due = 0;
        if (frame_sof_i) begin
            if (in_frame) begin
                $display("second start of frame before end of frame");
                ctrl_errs++;
            end
            in_frame = 1;
            got.delete();
        end
        if (in_frame && frame_valid_i && frame_grant_i) got.push_back(frame_data_i);
        if (frame_eof_i && !eof_q) begin
            if (in_frame) close_frame();
            else begin
                $display("end of frame seen without a start of frame");
                ctrl_errs++;
            end
            in_frame = 0;
        end
        eof_q = frame_eof_i;
    end

endmodule

/* sim/tb_switch_rx.sv */
module tb_switch_rx;
    import rx_tx_pkg::*;

    logic        switch_clk = 0, gmii_clk = 0, switch_rst_n = 0;
    logic [7:0]  gmii_data = 0;
    logic        gmii_dv = 0, gmii_er = 0, grant = 1;
    logic [7:0]  frame_data;
    logic        frame_valid, frame_sof, frame_eof, frame_error, lookup_valid, dst_hit;
    logic [47:0] mac_dst, mac_src;
    logic [47:0] f_dst[64], f_src[64], learned[$];   // learned mirrors the table contents
    int          f_len[64], f_first[64], f_bad[64], f_er[64], f_stall[64];
    int          n_frames = 0, stall_at = 0, taken_cnt = 0, fd, errs;
    longint      wd_limit;
    string       line;
    logic [47:0] d, s;
    int          l, f, c, e, st;

    always #4 switch_clk = ~switch_clk;
    always #5 gmii_clk = ~gmii_clk;   // writer slower than reader

    switch_rx_port dut (
        .gmii_rx_clk_i(gmii_clk), .gmii_rx_data_i(gmii_data),
        .gmii_rx_dv_i(gmii_dv), .gmii_rx_er_i(gmii_er),
        .switch_clk(switch_clk), .switch_rst_n(switch_rst_n), .frame_grant_i(grant),
        .frame_data_o(frame_data), .frame_valid_o(frame_valid), .frame_sof_o(frame_sof),
        .frame_eof_o(frame_eof), .frame_error_o(frame_error),
        .mac_dst_addr_o(mac_dst), .mac_src_addr_o(mac_src),
        .lookup_valid_o(lookup_valid), .dst_hit_o(dst_hit)
    );

    rx_checker u_chk (
        .switch_clk(switch_clk), .frame_data_i(frame_data), .frame_valid_i(frame_valid),
        .frame_grant_i(grant), .frame_sof_i(frame_sof), .frame_eof_i(frame_eof),
        .frame_error_i(frame_error), .mac_dst_addr_i(mac_dst), .mac_src_addr_i(mac_src),
        .lookup_valid_i(lookup_valid), .dst_hit_i(dst_hit)
    );

    // reference learning rule, lookup first then learn a new src
    function automatic logic update_table_model(input logic [47:0] dst, input logic [47:0] src);
        logic hit, found;
        hit = 0;
        found = 0;
        foreach (learned[j]) begin
            if (learned[j] == dst) hit = 1;
            if (learned[j] == src) found = 1;
        end
        if (!found) begin
            learned.push_back(src);
            if (learned.size() > TABLE_DEPTH) void'(learned.pop_front());   // oldest goes
        end
        return hit;
    endfunction

    task automatic send_byte(input logic [7:0] b, input logic er);
        @(negedge gmii_clk);
        gmii_data = b;
        gmii_dv   = 1;
        gmii_er   = er;
    endtask

    task automatic send_frame(input int i);
        logic [7:0]  fb[$];
        logic [31:0] crc;
        logic        bad, hit;
        int          gap;
        for (int k = 0; k < 6; k++) fb.push_back(f_dst[i][47-8*k -: 8]);
        for (int k = 0; k < 6; k++) fb.push_back(f_src[i][47-8*k -: 8]);
        fb.push_back(8'(f_len[i] >> 8));   // length field in place of ethertype
        fb.push_back(8'(f_len[i]));
        fb.push_back(8'(f_first[i]));
        for (int k = 1; k < f_len[i]; k++) fb.push_back(8'($urandom));
        crc = CRC_INIT;
        foreach (fb[k]) crc = crc32_next(fb[k], crc);
        if (f_bad[i] != 0) crc = ~crc;
        for (int k = 3; k >= 0; k--) fb.push_back(crc[8*k +: 8]);   // msb byte first
        bad = (f_bad[i] != 0) || (f_er[i] != 0);
        hit = bad ? 1'b0 : update_table_model(f_dst[i], f_src[i]);
        foreach (fb[k]) u_chk.push_byte(fb[k]);
        u_chk.push_frame(fb.size(), bad, hit, f_dst[i], f_src[i]);
        stall_at = f_stall[i];
        repeat (7) send_byte(PREAMBLE_BYTE, 0);
        send_byte(SFD_BYTE, 0);
        foreach (fb[k]) send_byte(fb[k], (k + 1) == f_er[i]);
        @(negedge gmii_clk);
        gmii_dv   = 0;
        gmii_er   = 0;
        gmii_data = 0;
        gap = 12 + int'($urandom % 9);
        repeat (gap - 1) @(negedge gmii_clk);
    endtask

    // bytes taken by the memory side in the current frame, back to zero once eof is up
    always @(posedge switch_clk) begin
        if (frame_valid && grant) taken_cnt <= frame_sof ? 1 : taken_cnt + 1;
        else if (frame_eof) taken_cnt <= 0;
    end

    initial begin
        forever begin
            @(negedge switch_clk);
            if (stall_at != 0 && taken_cnt >= stall_at) begin
                stall_at = 0;
                grant = 0;
                repeat (4) @(negedge switch_clk);
                grant = 1;
            end
        end
    end

    initial begin
        void'($urandom(32'hd1b9));
        fd = $fopen("sim/frames_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the frame input file");
            $display("STATUS: FAIL");
            $finish;
        end
        wd_limit = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#" &&
                $sscanf(line, "%h %h %d %h %d %d %d", d, s, l, f, c, e, st) == 7) begin
                f_dst[n_frames] = d;
                f_src[n_frames] = s;
                f_len[n_frames] = l;
                f_first[n_frames] = f;
                f_bad[n_frames] = c;
                f_er[n_frames] = e;
                f_stall[n_frames] = st;
                wd_limit += 8 + 14 + l + 4 + 20;   // preamble, header, payload, fcs, gap
                n_frames++;
            end
        end
        $fclose(fd);
        wd_limit = wd_limit * 10 * 2 + 1000;
        fork
            begin
                #(wd_limit);
                $display("watchdog expired with %0d of %0d frames checked",
                         u_chk.frames_done, n_frames);
                $display("STATUS: FAIL");
                $finish;
            end
        join_none
        repeat (2) @(posedge switch_clk);
        @(negedge switch_clk);
        switch_rst_n = 1;
        repeat (10) @(negedge gmii_clk);   // gmii side reset release
        for (int i = 0; i < n_frames; i++) send_frame(i);
        wait (u_chk.frames_done == n_frames);
        repeat (4) @(posedge switch_clk);
        errs = u_chk.data_errs + u_chk.ctrl_errs + u_chk.lookup_errs;
        $display("frames %0d, data errors %0d, control errors %0d, lookup errors %0d",
                 n_frames, u_chk.data_errs, u_chk.ctrl_errs, u_chk.lookup_errs);
        if (errs == 0) $display("STATUS: PASS");
        else $display("STATUS: FAIL");
        $finish;
    end

endmodule
